//--- hw/egr_config.svh
`ifndef EGR_CONFIG_SVH
`define EGR_CONFIG_SVH

// ==================================================
// egress stage build parameters
// ==================================================

// number of egress ports, each with its own ingress and h2c source.
`define EGR_NUM_PORTS 2

// payload bytes per beat.
`define EGR_DATA_BYTES 8

// routing tag width carried on tdest.
`define EGR_TDEST_W 2

// register word-address width.
// must cover REG_CNT_BASE plus 2 counters per port.
`define EGR_REG_ADDR_W 4

`endif

//--- hw/egr_pkg.sv
`default_nettype none

`include "egr_config.svh"

package egr_pkg;

    // ==================================================
    // stream field types
    // ==================================================
    typedef logic [8*`EGR_DATA_BYTES-1:0] data_t;   // one beat of payload.
    typedef logic [`EGR_DATA_BYTES-1:0]   keep_t;   // byte-valid mask.
    typedef logic [`EGR_TDEST_W-1:0]      dest_t;   // routing tag.

    // ==================================================
    // register bus types and map
    // ==================================================
    typedef logic [`EGR_REG_ADDR_W-1:0] reg_addr_t;  // word address.
    typedef logic [31:0]                reg_data_t;  // register word.
    typedef logic [31:0]                cnt_t;       // packet counter, wraps.

    // control word. bit 2p = ingress enable, bit 2p+1 = h2c enable of port p.
    localparam reg_addr_t REG_CTRL     = reg_addr_t'(0);
    // counter for port p, source s sits at REG_CNT_BASE + 2p + s.
    localparam reg_addr_t REG_CNT_BASE = reg_addr_t'(4);

    // packet mux grant state.
    typedef enum logic [1:0] {
        MUX_IDLE,      // between packets, arbitrating.
        MUX_PKT_IN,    // ingress packet in progress.
        MUX_PKT_H2C    // h2c packet in progress.
    } mux_state_e;

endpackage

`default_nettype wire

//--- hw/axis_skid_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_slice (
    input  logic              core_clk,
    input  logic              arst_n,

    // upstream side.
    input  logic              s_tvalid,
    input  logic              s_tlast,
    input  egr_pkg::data_t    s_tdata,
    input  egr_pkg::keep_t    s_tkeep,
    input  egr_pkg::dest_t    s_tdest,
    output logic              s_tready,

    // downstream side.
    output logic              m_tvalid,
    output logic              m_tlast,
    output egr_pkg::data_t    m_tdata,
    output egr_pkg::keep_t    m_tkeep,
    output egr_pkg::dest_t    m_tdest,
    input  logic              m_tready
);

    // ==================================================
    // skid entry and handshake terms
    // ==================================================
    logic           skid_valid_q;   // skid register holds a beat.
    logic           skid_valid_d;
    logic           skid_tlast;
    egr_pkg::data_t skid_tdata;
    egr_pkg::keep_t skid_tkeep;
    egr_pkg::dest_t skid_tdest;

    logic           out_load;       // main register may take a new beat.
    logic           in_fire;        // upstream beat accepted this cycle.

    assign out_load = m_tready || !m_tvalid;
    assign in_fire  = s_tvalid && s_tready;

    // skid fills only when a beat arrives while the output is stalled.
    always_comb begin
        skid_valid_d = skid_valid_q;
        if (out_load) begin
            skid_valid_d = 1'b0;           // drains into the main register.
        end else if (in_fire) begin
            skid_valid_d = 1'b1;           // in-flight beat caught here.
        end
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid     <= 1'b0;
            skid_valid_q <= 1'b0;
            s_tready     <= 1'b0;          // opens one cycle after reset.
        end else begin
            skid_valid_q <= skid_valid_d;
            s_tready     <= !skid_valid_d; // registered ready, cuts the path.
            if (out_load) begin
                m_tvalid <= skid_valid_q || in_fire;
            end
        end
    end

    // payload path. skid beat is always older, so it goes out first.
    always_ff @(posedge core_clk) begin
        if (out_load) begin
            m_tdata <= skid_valid_q ? skid_tdata : s_tdata;
            m_tkeep <= skid_valid_q ? skid_tkeep : s_tkeep;
            m_tdest <= skid_valid_q ? skid_tdest : s_tdest;
            m_tlast <= skid_valid_q ? skid_tlast : s_tlast;
        end
        if (in_fire && !out_load) begin
            skid_tdata <= s_tdata;
            skid_tkeep <= s_tkeep;
            skid_tdest <= s_tdest;
            skid_tlast <= s_tlast;
        end
    end

    // a stalled output beat must not drop or change.
    a_hold_stalled : assert property (@(posedge core_clk) disable iff (!arst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
                                     && $stable(m_tdest) && $stable(m_tlast)));

endmodule

`default_nettype wire

//--- hw/axis_pkt_mux.sv
`timescale 1ns/1ps
`default_nettype none

module axis_pkt_mux (
    input  logic              core_clk,
    input  logic              arst_n,

    // source a carries the ingress pipeline.
    input  logic              a_tvalid,
    input  logic              a_tlast,
    input  egr_pkg::data_t    a_tdata,
    input  egr_pkg::keep_t    a_tkeep,
    input  egr_pkg::dest_t    a_tdest,
    output logic              a_tready,

    // source b carries host to card traffic.
    input  logic              b_tvalid,
    input  logic              b_tlast,
    input  egr_pkg::data_t    b_tdata,
    input  egr_pkg::keep_t    b_tkeep,
    input  egr_pkg::dest_t    b_tdest,
    output logic              b_tready,

    // merged output.
    output logic              m_tvalid,
    output logic              m_tlast,
    output egr_pkg::data_t    m_tdata,
    output egr_pkg::keep_t    m_tkeep,
    output egr_pkg::dest_t    m_tdest,
    input  logic              m_tready,

    input  logic [1:0]        src_en,    // bit 0 = a, bit 1 = b.
    output logic              pkt_done,  // one pulse per packet out.
    output logic              pkt_src    // source of that packet.
);

    egr_pkg::mux_state_e state_q;
    egr_pkg::mux_state_e state_d;
    logic last_src_q;    // winner of the previous packet.
    logic a_req;         // enabled and offering a beat.
    logic b_req;
    logic gnt;           // 0 = a, 1 = b.
    logic gnt_act;       // some source is connected.
    logic xfer;          // beat leaves the mux.

    // ==================================================
    // arbitration
    // ==================================================
    always_comb begin
        a_req   = a_tvalid && src_en[0];
        b_req   = b_tvalid && src_en[1];
        gnt     = 1'b0;
        gnt_act = 1'b0;
        case (state_q)
            egr_pkg::MUX_PKT_IN: begin
                gnt     = 1'b0;    // locked to a until tlast.
                gnt_act = 1'b1;
            end
            egr_pkg::MUX_PKT_H2C: begin
                gnt     = 1'b1;    // locked to b until tlast.
                gnt_act = 1'b1;
            end
            default: begin
                // round robin lets b win a tie unless it won last time.
                gnt_act = a_req || b_req;
                gnt     = b_req && (!a_req || !last_src_q);
            end
        endcase
    end

    // ==================================================
    // combinational datapath select
    // ==================================================
    assign m_tvalid = gnt_act && (gnt ? b_tvalid : a_tvalid);
    assign m_tlast  = gnt ? b_tlast : a_tlast;
    assign m_tdata  = gnt ? b_tdata : a_tdata;
    assign m_tkeep  = gnt ? b_tkeep : a_tkeep;
    assign m_tdest  = gnt ? b_tdest : a_tdest;

    assign a_tready = gnt_act && !gnt && m_tready;
    assign b_tready = gnt_act &&  gnt && m_tready;
    assign xfer     = m_tvalid && m_tready;

    // grant opens on the first beat and closes on the tlast transfer.
    always_comb begin
        state_d = state_q;
        if (xfer) begin
            if (m_tlast) begin
                state_d = egr_pkg::MUX_IDLE;   // re-arbitrate next cycle.
            end else begin
                state_d = gnt ? egr_pkg::MUX_PKT_H2C : egr_pkg::MUX_PKT_IN;
            end
        end
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= egr_pkg::MUX_IDLE;
            last_src_q <= 1'b1;          // first tie goes to ingress.
            pkt_done   <= 1'b0;
            pkt_src    <= 1'b0;
        end else begin
            state_q  <= state_d;
            pkt_done <= xfer && m_tlast;
            if (xfer && m_tlast) begin
                last_src_q <= gnt;
                pkt_src    <= gnt;
            end
        end
    end

    // mid-packet the same source stays connected, even across gaps.
    a_grant_held : assert property (@(posedge core_clk) disable iff (!arst_n)
        (xfer && !m_tlast) |=> (gnt_act && gnt == $past(gnt)));

endmodule

`default_nettype wire

//--- hw/egr_stats_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "egr_config.svh"

module egr_stats_regs (
    input  logic                          core_clk,
    input  logic                          arst_n,

    // register strobe bus.
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  egr_pkg::reg_addr_t            reg_addr,
    input  egr_pkg::reg_data_t            reg_wdata,
    output egr_pkg::reg_data_t            reg_rdata,
    output logic                          reg_rvalid,

    // packet reports from the muxes.
    input  logic [`EGR_NUM_PORTS-1:0]     pkt_done,
    input  logic [`EGR_NUM_PORTS-1:0]     pkt_src,

    output logic [2*`EGR_NUM_PORTS-1:0]   src_en    // 2 bits per port.
);

    localparam int NUM_CNT = 2 * `EGR_NUM_PORTS;   // one per port and source.

    egr_pkg::reg_data_t ctrl_q;                   // source enables.
    egr_pkg::cnt_t      cnt_q [NUM_CNT];          // packet counters.
    egr_pkg::reg_data_t rd_mux;

    // ==================================================
    // control register
    // ==================================================
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '1;                         // everything enabled.
        end else if (reg_wr && reg_addr == egr_pkg::REG_CTRL) begin
            ctrl_q <= reg_wdata;
        end
    end

    assign src_en = ctrl_q[2*`EGR_NUM_PORTS-1:0];

    // ==================================================
    // packet counters
    // ==================================================
    for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
        localparam egr_pkg::reg_addr_t CNT_ADDR =
            egr_pkg::reg_addr_t'(egr_pkg::REG_CNT_BASE + i);
        logic clr;    // software write to this counter.
        logic inc;    // matching packet finished.

        assign clr = reg_wr && reg_addr == CNT_ADDR;
        assign inc = pkt_done[i/2] && (pkt_src[i/2] == 1'(i % 2));

        always_ff @(posedge core_clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt_q[i] <= '0;
            end else if (clr) begin
                cnt_q[i] <= '0;                   // clear beats a same-cycle count.
            end else if (inc) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;      // wraps at the top.
            end
        end
    end

    // ==================================================
    // read path
    // ==================================================
    always_comb begin
        rd_mux = '0;                              // unused addresses read zero.
        if (reg_addr == egr_pkg::REG_CTRL) begin
            rd_mux = ctrl_q;
        end
        for (int i = 0; i < NUM_CNT; i++) begin
            if (reg_addr == egr_pkg::reg_addr_t'(egr_pkg::REG_CNT_BASE + i)) begin
                rd_mux = cnt_q[i];
            end
        end
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;                 // data one cycle after the strobe.
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- hw/egr_app.sv
`timescale 1ns/1ps
`default_nettype none

`include "egr_config.svh"

module egr_app (
    input  logic                                    core_clk,
    input  logic                                    arst_n,

    // ingress pipeline packets.
    input  logic [`EGR_NUM_PORTS-1:0]               in_tvalid,
    input  logic [`EGR_NUM_PORTS-1:0]               in_tlast,
    input  egr_pkg::data_t [`EGR_NUM_PORTS-1:0]     in_tdata,
    input  egr_pkg::keep_t [`EGR_NUM_PORTS-1:0]     in_tkeep,
    input  egr_pkg::dest_t [`EGR_NUM_PORTS-1:0]     in_tdest,
    output logic [`EGR_NUM_PORTS-1:0]               in_tready,

    // host to card packets.
    input  logic [`EGR_NUM_PORTS-1:0]               h2c_tvalid,
    input  logic [`EGR_NUM_PORTS-1:0]               h2c_tlast,
    input  egr_pkg::data_t [`EGR_NUM_PORTS-1:0]     h2c_tdata,
    input  egr_pkg::keep_t [`EGR_NUM_PORTS-1:0]     h2c_tkeep,
    input  egr_pkg::dest_t [`EGR_NUM_PORTS-1:0]     h2c_tdest,
    output logic [`EGR_NUM_PORTS-1:0]               h2c_tready,

    // merged egress stream.
    output logic [`EGR_NUM_PORTS-1:0]               out_tvalid,
    output logic [`EGR_NUM_PORTS-1:0]               out_tlast,
    output egr_pkg::data_t [`EGR_NUM_PORTS-1:0]     out_tdata,
    output egr_pkg::keep_t [`EGR_NUM_PORTS-1:0]     out_tkeep,
    output egr_pkg::dest_t [`EGR_NUM_PORTS-1:0]     out_tdest,
    input  logic [`EGR_NUM_PORTS-1:0]               out_tready,

    // register strobe bus.
    input  logic                                    reg_wr,
    input  logic                                    reg_rd,
    input  egr_pkg::reg_addr_t                      reg_addr,
    input  egr_pkg::reg_data_t                      reg_wdata,
    output egr_pkg::reg_data_t                      reg_rdata,
    output logic                                    reg_rvalid
);

    logic [`EGR_NUM_PORTS-1:0]   pkt_done;   // per-port packet report.
    logic [`EGR_NUM_PORTS-1:0]   pkt_src;
    logic [2*`EGR_NUM_PORTS-1:0] src_en;     // per-port source enables.

    // ==================================================
    // per-port datapath: slices into mux into slice
    // ==================================================
    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_port
        // ingress slice to mux.
        logic a_tvalid, a_tlast, a_tready;
        egr_pkg::data_t a_tdata;
        egr_pkg::keep_t a_tkeep;
        egr_pkg::dest_t a_tdest;
        // h2c slice to mux.
        logic b_tvalid, b_tlast, b_tready;
        egr_pkg::data_t b_tdata;
        egr_pkg::keep_t b_tkeep;
        egr_pkg::dest_t b_tdest;
        // mux to output slice.
        logic m_tvalid, m_tlast, m_tready;
        egr_pkg::data_t m_tdata;
        egr_pkg::keep_t m_tkeep;
        egr_pkg::dest_t m_tdest;

        axis_skid_slice u_in_slice (
            .core_clk, .arst_n,
            .s_tvalid (in_tvalid[p]), .s_tlast (in_tlast[p]), .s_tdata (in_tdata[p]),
            .s_tkeep  (in_tkeep[p]),  .s_tdest (in_tdest[p]), .s_tready (in_tready[p]),
            .m_tvalid (a_tvalid), .m_tlast (a_tlast), .m_tdata (a_tdata),
            .m_tkeep  (a_tkeep),  .m_tdest (a_tdest), .m_tready (a_tready)
        );

        axis_skid_slice u_h2c_slice (
            .core_clk, .arst_n,
            .s_tvalid (h2c_tvalid[p]), .s_tlast (h2c_tlast[p]), .s_tdata (h2c_tdata[p]),
            .s_tkeep  (h2c_tkeep[p]),  .s_tdest (h2c_tdest[p]), .s_tready (h2c_tready[p]),
            .m_tvalid (b_tvalid), .m_tlast (b_tlast), .m_tdata (b_tdata),
            .m_tkeep  (b_tkeep),  .m_tdest (b_tdest), .m_tready (b_tready)
        );

        axis_pkt_mux u_mux (
            .core_clk, .arst_n,
            .a_tvalid, .a_tlast, .a_tdata, .a_tkeep, .a_tdest, .a_tready,
            .b_tvalid, .b_tlast, .b_tdata, .b_tkeep, .b_tdest, .b_tready,
            .m_tvalid, .m_tlast, .m_tdata, .m_tkeep, .m_tdest, .m_tready,
            .src_en   (src_en[2*p +: 2]),
            .pkt_done (pkt_done[p]),
            .pkt_src  (pkt_src[p])
        );

        axis_skid_slice u_out_slice (
            .core_clk, .arst_n,
            .s_tvalid (m_tvalid), .s_tlast (m_tlast), .s_tdata (m_tdata),
            .s_tkeep  (m_tkeep),  .s_tdest (m_tdest), .s_tready (m_tready),
            .m_tvalid (out_tvalid[p]), .m_tlast (out_tlast[p]), .m_tdata (out_tdata[p]),
            .m_tkeep  (out_tkeep[p]),  .m_tdest (out_tdest[p]), .m_tready (out_tready[p])
        );
    end

    // software control and packet statistics.
    egr_stats_regs u_regs (
        .core_clk, .arst_n,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .pkt_done, .pkt_src, .src_en
    );

endmodule

`default_nettype wire

//--- test/tb_egr_app.sv
`timescale 1ns/1ps
`default_nettype none

`include "egr_config.svh"

module tb_egr_app;

    localparam int NP       = `EGR_NUM_PORTS;
    localparam int RDY_HIGH = 0;    // out_tready modes per port.
    localparam int RDY_RAND = 1;
    localparam int RDY_LOW  = 2;

    typedef struct packed {
        logic           last;
        egr_pkg::dest_t dest;
        egr_pkg::keep_t keep;
        egr_pkg::data_t data;
    } beat_t;

    // ==================================================
    // DUT signals
    // ==================================================
    logic                      core_clk = 1'b0;
    logic                      arst_n;
    logic [NP-1:0]             in_tvalid = '0;
    logic [NP-1:0]             in_tlast = '0;
    egr_pkg::data_t [NP-1:0]   in_tdata = '0;
    egr_pkg::keep_t [NP-1:0]   in_tkeep = '0;
    egr_pkg::dest_t [NP-1:0]   in_tdest = '0;
    logic [NP-1:0]             in_tready;
    logic [NP-1:0]             h2c_tvalid = '0;
    logic [NP-1:0]             h2c_tlast = '0;
    egr_pkg::data_t [NP-1:0]   h2c_tdata = '0;
    egr_pkg::keep_t [NP-1:0]   h2c_tkeep = '0;
    egr_pkg::dest_t [NP-1:0]   h2c_tdest = '0;
    logic [NP-1:0]             h2c_tready;
    logic [NP-1:0]             out_tvalid;
    logic [NP-1:0]             out_tlast;
    egr_pkg::data_t [NP-1:0]   out_tdata;
    egr_pkg::keep_t [NP-1:0]   out_tkeep;
    egr_pkg::dest_t [NP-1:0]   out_tdest;
    logic [NP-1:0]             out_tready = '1;
    logic                      reg_wr;
    logic                      reg_rd;
    egr_pkg::reg_addr_t        reg_addr;
    egr_pkg::reg_data_t        reg_wdata;
    egr_pkg::reg_data_t        reg_rdata;
    logic                      reg_rvalid;

    // ==================================================
    // scoreboard state
    // ==================================================
    beat_t snd_q [NP][2][$];     // beats still to be driven per port and source.
    beat_t exp_q [NP][2][$];     // beats still expected at out_*.
    int    order_q [NP][$];      // source of each finished output packet.
    int    pkt_cnt [NP][2];      // packets sent since the last counter clear.
    bit    in_pkt [NP];          // output packet open on this port.
    int    cur_src [NP];
    int    rdy_mode [NP];
    bit    fire [NP][2];
    int    beats_sent = 0;
    int    cyc = 0;
    int    lat_acc = -1;         // first ingress accept on port 0.
    int    lat_out = -1;         // first out_tvalid on port 0.
    logic [15:0] lfsr_q = 16'd62055;

    egr_app u_egr_app (
        .core_clk, .arst_n,
        .in_tvalid, .in_tlast, .in_tdata, .in_tkeep, .in_tdest, .in_tready,
        .h2c_tvalid, .h2c_tlast, .h2c_tdata, .h2c_tkeep, .h2c_tdest, .h2c_tready,
        .out_tvalid, .out_tlast, .out_tdata, .out_tkeep, .out_tdest, .out_tready,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid
    );

    always #5 core_clk = ~core_clk;     // 10 ns period.

    always @(posedge core_clk) cyc <= cyc + 1;

    // feedback taps x^16 + x^14 + x^13 + x^11 stepped once per bit.
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // watchdog budget grows with every beat queued.
    always @(posedge core_clk) begin
        if (cyc > beats_sent * 20 + 2000) begin
            $display("timeout: run still busy after %0d cycles", cyc);
            stop_run();
        end
    end

    // ==================================================
    // stream driver and output monitor
    // ==================================================
    task automatic present_beat(input int p, input int s);
        beat_t b;
        logic  vld;
        vld = snd_q[p][s].size() > 0;
        b   = vld ? snd_q[p][s][0] : '0;
        if (s == 0) begin
            in_tvalid[p] = vld;
            in_tlast[p]  = b.last;
            in_tdata[p]  = b.data;
            in_tkeep[p]  = b.keep;
            in_tdest[p]  = b.dest;
        end else begin
            h2c_tvalid[p] = vld;
            h2c_tlast[p]  = b.last;
            h2c_tdata[p]  = b.data;
            h2c_tkeep[p]  = b.keep;
            h2c_tdest[p]  = b.dest;
        end
    endtask

    always @(posedge core_clk) begin
        for (int p = 0; p < NP; p++) begin
            fire[p][0] = in_tvalid[p] && in_tready[p];     // pre-edge handshake.
            fire[p][1] = h2c_tvalid[p] && h2c_tready[p];
        end
        if (fire[0][0] && lat_acc < 0) begin
            lat_acc = cyc;
        end
        #1;
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < 2; s++) begin
                if (fire[p][s]) begin
                    void'(snd_q[p][s].pop_front());
                end
                present_beat(p, s);
            end
            case (rdy_mode[p])
                RDY_RAND: out_tready[p] = lfsr_bit();
                RDY_LOW:  out_tready[p] = 1'b0;
                default:  out_tready[p] = 1'b1;
            endcase
        end
    end

    // source comes from the marker in the top payload byte.
    task automatic check_beat(input int p);
        beat_t exp;
        int    src;
        src = int'(out_tdata[p][56]);
        assert (!in_pkt[p] || src == cur_src[p]) else begin
            $display("port %0d interleaved a beat of another packet at %0t", p, $time);
            stop_run();
        end
        assert (exp_q[p][src].size() > 0) else begin
            $display("port %0d sent a beat of source %0d that was never expected", p, src);
            stop_run();
        end
        exp = exp_q[p][src].pop_front();
        check_val($sformatf("out_tdata[%0d]", p), out_tdata[p], exp.data);
        check_val($sformatf("out_tkeep[%0d]", p), out_tkeep[p], exp.keep);
        check_val($sformatf("out_tdest[%0d]", p), out_tdest[p], exp.dest);
        check_val($sformatf("out_tlast[%0d]", p), out_tlast[p], exp.last);
        in_pkt[p]  = !out_tlast[p];
        cur_src[p] = src;
        if (out_tlast[p]) begin
            order_q[p].push_back(src);
        end
    endtask

    always @(posedge core_clk) begin
        if (out_tvalid[0] && lat_out < 0) begin
            lat_out = cyc;
        end
        for (int p = 0; p < NP; p++) begin
            if (out_tvalid[p] && out_tready[p]) begin
                check_beat(p);
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    task automatic queue_pkt(input int p, input int s, input int len);
        beat_t          b;
        egr_pkg::dest_t dest;
        logic [63:0]    r;
        int             nb;
        dest = egr_pkg::dest_t'(rand_bits(2));
        for (int i = 0; i < len; i++) begin
            r      = rand_bits(48);
            b.data = {8'h80 | 8'(p << 4) | 8'(s), 8'(pkt_cnt[p][s]), r[47:0]};
            b.keep = '1;
            b.last = (i == len - 1);
            b.dest = dest;
            if (b.last) begin
                nb     = int'(rand_bits(3)) + 1;                 // 1..8 valid bytes.
                b.keep = egr_pkg::keep_t'((1 << nb) - 1);
            end
            snd_q[p][s].push_back(b);
            exp_q[p][s].push_back(b);
        end
        pkt_cnt[p][s]++;
        beats_sent += len;
    endtask

    function automatic int rand_len();
        return 1 + int'(rand_bits(3)) % 6;
    endfunction

    function automatic bit all_idle();
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < 2; s++) begin
                if (snd_q[p][s].size() != 0 || exp_q[p][s].size() != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        while (!all_idle()) begin
            @(posedge core_clk);
        end
        @(posedge core_clk);
    endtask

    task automatic reg_write(input egr_pkg::reg_addr_t addr, input egr_pkg::reg_data_t data);
        @(posedge core_clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge core_clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // rdata comes exactly one cycle after the strobe.
    task automatic check_reg(input egr_pkg::reg_addr_t addr, input egr_pkg::reg_data_t exp);
        @(posedge core_clk);
        #1;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge core_clk);
        #1;
        reg_rd = 1'b0;
        assert (reg_rvalid === 1'b1) else begin
            $display("read of address %0d gave no reg_rvalid one cycle later", addr);
            stop_run();
        end
        check_val($sformatf("reg_rdata @%0d", addr), reg_rdata, exp);
    endtask

    function automatic egr_pkg::reg_addr_t cnt_addr(input int p, input int s);
        return egr_pkg::reg_addr_t'(egr_pkg::REG_CNT_BASE + 2 * p + s);
    endfunction

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_single_packet();
        queue_pkt(0, 0, 4);
        wait_drain();
        check_val("out_tvalid latency", lat_out - lat_acc, 2);
    endtask

    task automatic test_merge_order();
        for (int p = 0; p < NP; p++) begin
            order_q[p].delete();
        end
        for (int n = 0; n < 4; n++) begin
            for (int p = 0; p < NP; p++) begin
                queue_pkt(p, 0, rand_len());
                queue_pkt(p, 1, rand_len());
            end
        end
        wait_drain();
        for (int p = 0; p < NP; p++) begin
            check_val($sformatf("packets out on port %0d", p), order_q[p].size(), 8);
            for (int i = 1; i < order_q[p].size(); i++) begin
                assert (order_q[p][i] != order_q[p][i-1]) else begin
                    $display("port %0d packet %0d repeats source %0d", p, i, order_q[p][i]);
                    stop_run();
                end
            end
        end
    endtask

    task automatic test_backpressure();
        for (int p = 0; p < NP; p++) begin
            rdy_mode[p] = RDY_RAND;
        end
        for (int n = 0; n < 5; n++) begin
            for (int p = 0; p < NP; p++) begin
                queue_pkt(p, 0, rand_len());
                queue_pkt(p, 1, rand_len());
            end
        end
        wait_drain();
        rdy_mode[1] = RDY_LOW;          // port 1 blocked while port 0 keeps moving.
        for (int n = 0; n < 3; n++) begin
            for (int p = 0; p < NP; p++) begin
                queue_pkt(p, 0, rand_len());
                queue_pkt(p, 1, rand_len());
            end
        end
        while (exp_q[0][0].size() + exp_q[0][1].size() > 0) begin
            @(posedge core_clk);
        end
        check_val("out_tvalid[1]", out_tvalid[1], 1'b1);   // beat parked at the stalled port.
        rdy_mode[1] = RDY_RAND;
        wait_drain();
        for (int p = 0; p < NP; p++) begin
            rdy_mode[p] = RDY_HIGH;
        end
    endtask

    task automatic test_source_enable();
        int held;
        check_reg(egr_pkg::REG_CTRL, 32'hFFFF_FFFF);     // reset value.
        reg_write(egr_pkg::REG_CTRL, 32'hFFFF_FFFD);     // port 0 h2c off.
        check_reg(egr_pkg::REG_CTRL, 32'hFFFF_FFFD);
        for (int n = 0; n < 3; n++) begin
            queue_pkt(0, 0, rand_len());
            queue_pkt(0, 1, rand_len());
        end
        held = exp_q[0][1].size();
        while (exp_q[0][0].size() > 0) begin
            @(posedge core_clk);
        end
        repeat (20) @(posedge core_clk);
        check_val("h2c beats held on port 0", exp_q[0][1].size(), held);
        reg_write(egr_pkg::REG_CTRL, 32'hFFFF_FFFF);
        wait_drain();
    endtask

    task automatic test_counters();
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < 2; s++) begin
                check_reg(cnt_addr(p, s), pkt_cnt[p][s]);
                reg_write(cnt_addr(p, s), 32'h0);        // any write clears.
                check_reg(cnt_addr(p, s), 32'h0);
                pkt_cnt[p][s] = 0;
            end
        end
        check_reg(egr_pkg::reg_addr_t'(2), 32'h0);       // holes in the map.
        check_reg(cnt_addr(NP, 0), 32'h0);
        queue_pkt(1, 1, 3);
        wait_drain();
        check_reg(cnt_addr(1, 1), 32'h1);
    endtask

    initial begin
        arst_n    = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (16) @(posedge core_clk);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge core_clk);
        test_single_packet();
        test_merge_order();
        test_backpressure();
        test_source_enable();
        test_counters();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/egr_pkg.sv
hw/axis_skid_slice.sv
hw/axis_pkt_mux.sv
hw/egr_stats_regs.sv
hw/egr_app.sv
test/tb_egr_app.sv

//--- run.sh
#!/bin/sh
# build the egress testbench with Verilator, run it, then scan the log.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_egr_app -f vlog.f \
    > build.log 2>&1 || { cat build.log; echo "verilator build error"; exit 1; }

./obj_dir/Vtb_egr_app > sim.log 2>&1
cat sim.log

# the log decides: any fail line fails the run, and a pass line must be present.
grep -q "Simulation failed" sim.log && { echo "run.sh: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "run.sh: no pass line"; exit 1; }
echo "run.sh: PASS"
exit 0
